/* logic/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // address map, byte addresses.
  localparam logic [31:0] SRAM_BASE     = 32'h0f00_0000;
  localparam logic [31:0] SRAM_SIZE     = 32'h0000_0400;
  localparam logic [31:0] RTC_ADDR      = 32'h0200_bff8;
  localparam logic [31:0] RTC_ADDR_HIGH = 32'h0200_bffc;
  localparam logic [31:0] UART_BASE     = 32'h1000_0000;
  localparam logic [31:0] UART_SIZE     = 32'h0000_1000;
  localparam logic [31:0] GPIO_BASE     = 32'h1000_2000;
  localparam logic [31:0] GPIO_SIZE     = 32'h0000_0010;

  // one word is 64 bits, so the window holds 1 KiB.
  localparam int SRAM_WORDS = 128;

  typedef enum logic [1:0] {
    ZONE_OTHER,
    ZONE_MEM,
    ZONE_RTC,
    ZONE_DEVICE
  } zone_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } slave_state_e;

  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
  } rd_req_t;

  typedef struct packed {
    logic        arready;
    logic        rvalid;
    resp_e       rresp;
    logic [63:0] rdata;
  } rd_rsp_t;

  typedef struct packed {
    logic        awvalid;
    logic [31:0] awaddr;
    logic        wvalid;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        bready;
  } wr_req_t;

  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_e bresp;
  } wr_rsp_t;

endpackage

`default_nettype wire

/* logic/axi_xbar.sv */
`default_nettype none

module axi_xbar (
  input  wire soc_bus_pkg::rd_req_t m_rd_req,
  input  wire soc_bus_pkg::wr_req_t m_wr_req,
  input  wire soc_bus_pkg::rd_rsp_t mem_rd_rsp,
  input  wire soc_bus_pkg::rd_rsp_t rtc_rd_rsp,
  input  wire soc_bus_pkg::wr_rsp_t mem_wr_rsp,
  input  wire soc_bus_pkg::wr_rsp_t rtc_wr_rsp,
  output soc_bus_pkg::rd_rsp_t      m_rd_rsp,
  output soc_bus_pkg::wr_rsp_t      m_wr_rsp,
  output soc_bus_pkg::rd_req_t      mem_rd_req,
  output soc_bus_pkg::rd_req_t      rtc_rd_req,
  output soc_bus_pkg::wr_req_t      mem_wr_req,
  output soc_bus_pkg::wr_req_t      rtc_wr_req,
  output logic                      diff_skip
);

  soc_bus_pkg::zone_e read_zone;
  soc_bus_pkg::zone_e write_zone;

  // uart wins over everything, gpio is checked last.
  function automatic soc_bus_pkg::zone_e classify(input logic [31:0] addr);
    soc_bus_pkg::zone_e zone;
    if (addr >= soc_bus_pkg::UART_BASE &&
        addr < soc_bus_pkg::UART_BASE + soc_bus_pkg::UART_SIZE) begin
      zone = soc_bus_pkg::ZONE_DEVICE;
    end else if (addr == soc_bus_pkg::RTC_ADDR ||
                 addr == soc_bus_pkg::RTC_ADDR_HIGH) begin
      zone = soc_bus_pkg::ZONE_RTC;
    end else if (addr >= soc_bus_pkg::SRAM_BASE &&
                 addr < soc_bus_pkg::SRAM_BASE + soc_bus_pkg::SRAM_SIZE) begin
      zone = soc_bus_pkg::ZONE_MEM;
    end else if (addr >= soc_bus_pkg::GPIO_BASE &&
                 addr < soc_bus_pkg::GPIO_BASE + soc_bus_pkg::GPIO_SIZE) begin
      zone = soc_bus_pkg::ZONE_DEVICE;
    end else begin
      zone = soc_bus_pkg::ZONE_OTHER;
    end
    return zone;
  endfunction

  always_comb begin
    read_zone  = classify(m_rd_req.araddr);
    write_zone = classify(m_wr_req.awaddr);
  end

  // device and timer traffic is not comparable against the reference model.
  always_comb begin
    diff_skip = read_zone == soc_bus_pkg::ZONE_DEVICE ||
                write_zone == soc_bus_pkg::ZONE_DEVICE ||
                read_zone == soc_bus_pkg::ZONE_RTC ||
                write_zone == soc_bus_pkg::ZONE_RTC;
  end

  // read channel steering.
  always_comb begin
    mem_rd_req = '0;
    rtc_rd_req = '0;
    if (read_zone == soc_bus_pkg::ZONE_RTC) begin
      rtc_rd_req = m_rd_req;
      m_rd_rsp   = rtc_rd_rsp;
    end else begin
      mem_rd_req = m_rd_req;
      m_rd_rsp   = mem_rd_rsp;
    end
  end

  // write channel steering.
  always_comb begin
    mem_wr_req = '0;
    rtc_wr_req = '0;
    if (write_zone == soc_bus_pkg::ZONE_RTC) begin
      rtc_wr_req = m_wr_req;
      m_wr_rsp   = rtc_wr_rsp;
    end else begin
      mem_wr_req = m_wr_req;
      m_wr_rsp   = mem_wr_rsp;
    end
  end

endmodule

`default_nettype wire

/* logic/sram_slave.sv */
`default_nettype none

module sram_slave (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire soc_bus_pkg::rd_req_t rd_req,
  input  wire soc_bus_pkg::wr_req_t wr_req,
  output soc_bus_pkg::rd_rsp_t      rd_rsp,
  output soc_bus_pkg::wr_rsp_t      wr_rsp
);

  logic [63:0] mem [soc_bus_pkg::SRAM_WORDS];

  soc_bus_pkg::slave_state_e rd_state;
  soc_bus_pkg::slave_state_e wr_state;
  logic                      rd_fire;
  logic                      wr_fire;
  logic                      rd_hit;
  logic                      wr_hit;
  logic [63:0]               rdata_q;
  soc_bus_pkg::resp_e        rresp_q;
  soc_bus_pkg::resp_e        bresp_q;

  function automatic logic in_window(input logic [31:0] addr);
    return addr >= soc_bus_pkg::SRAM_BASE &&
           addr < soc_bus_pkg::SRAM_BASE + soc_bus_pkg::SRAM_SIZE;
  endfunction

  always_comb begin
    rd_hit  = in_window(rd_req.araddr);
    wr_hit  = in_window(wr_req.awaddr);
    rd_fire = rd_state == soc_bus_pkg::ST_IDLE && rd_req.arvalid;
    // address and data are taken together.
    wr_fire = wr_state == soc_bus_pkg::ST_IDLE && wr_req.awvalid && wr_req.wvalid;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= soc_bus_pkg::ST_IDLE;
    end else if (rd_fire) begin
      rd_state <= soc_bus_pkg::ST_RESP;
    end else if (rd_state == soc_bus_pkg::ST_RESP && rd_req.rready) begin
      rd_state <= soc_bus_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= soc_bus_pkg::ST_IDLE;
    end else if (wr_fire) begin
      wr_state <= soc_bus_pkg::ST_RESP;
    end else if (wr_state == soc_bus_pkg::ST_RESP && wr_req.bready) begin
      wr_state <= soc_bus_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rdata_q <= rd_hit ? mem[rd_req.araddr[9:3]] : '0;
      rresp_q <= rd_hit ? soc_bus_pkg::RESP_OKAY : soc_bus_pkg::RESP_SLVERR;
    end
    if (wr_fire) begin
      bresp_q <= wr_hit ? soc_bus_pkg::RESP_OKAY : soc_bus_pkg::RESP_SLVERR;
    end
  end

  // byte merge under the strobes.
  always_ff @(posedge clock) begin
    if (wr_fire && wr_hit) begin
      for (int i = 0; i < 8; i++) begin
        if (wr_req.wstrb[i]) begin
          mem[wr_req.awaddr[9:3]][8*i +: 8] <= wr_req.wdata[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    rd_rsp.arready = rd_state == soc_bus_pkg::ST_IDLE;
    rd_rsp.rvalid  = rd_state == soc_bus_pkg::ST_RESP;
    rd_rsp.rresp   = rresp_q;
    rd_rsp.rdata   = rdata_q;
    wr_rsp.awready = wr_fire;
    wr_rsp.wready  = wr_fire;
    wr_rsp.bvalid  = wr_state == soc_bus_pkg::ST_RESP;
    wr_rsp.bresp   = bresp_q;
  end

endmodule

`default_nettype wire

/* logic/clint_timer.sv */
`default_nettype none

module clint_timer (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire soc_bus_pkg::rd_req_t rd_req,
  input  wire soc_bus_pkg::wr_req_t wr_req,
  output soc_bus_pkg::rd_rsp_t      rd_rsp,
  output soc_bus_pkg::wr_rsp_t      wr_rsp
);

  soc_bus_pkg::slave_state_e rd_state;
  soc_bus_pkg::slave_state_e wr_state;
  logic                      rd_fire;
  logic                      wr_fire;
  logic [63:0]               mtime;
  logic [31:0]               rdata_q;

  always_comb begin
    rd_fire = rd_state == soc_bus_pkg::ST_IDLE && rd_req.arvalid;
    wr_fire = wr_state == soc_bus_pkg::ST_IDLE && wr_req.awvalid && wr_req.wvalid;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_state <= soc_bus_pkg::ST_IDLE;
      wr_state <= soc_bus_pkg::ST_IDLE;
    end else begin
      if (rd_fire) begin
        rd_state <= soc_bus_pkg::ST_RESP;
      end else if (rd_state == soc_bus_pkg::ST_RESP && rd_req.rready) begin
        rd_state <= soc_bus_pkg::ST_IDLE;
      end
      if (wr_fire) begin
        wr_state <= soc_bus_pkg::ST_RESP;
      end else if (wr_state == soc_bus_pkg::ST_RESP && wr_req.bready) begin
        wr_state <= soc_bus_pkg::ST_IDLE;
      end
    end
  end

  // address bit 2 picks the high half. a write replaces the tick.
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else if (wr_fire && |wr_req.wstrb[3:0]) begin
      if (wr_req.awaddr[2]) begin
        mtime[63:32] <= wr_req.wdata[31:0];
      end else begin
        mtime[31:0] <= wr_req.wdata[31:0];
      end
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rdata_q <= rd_req.araddr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

  always_comb begin
    rd_rsp.arready = rd_state == soc_bus_pkg::ST_IDLE;
    rd_rsp.rvalid  = rd_state == soc_bus_pkg::ST_RESP;
    rd_rsp.rresp   = soc_bus_pkg::RESP_OKAY;
    rd_rsp.rdata   = {32'd0, rdata_q};
    wr_rsp.awready = wr_fire;
    wr_rsp.wready  = wr_fire;
    wr_rsp.bvalid  = wr_state == soc_bus_pkg::ST_RESP;
    wr_rsp.bresp   = soc_bus_pkg::RESP_OKAY;
  end

endmodule

`default_nettype wire

/* logic/soc_bus_top.sv */
`default_nettype none

module soc_bus_top (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire soc_bus_pkg::rd_req_t m_rd_req,
  input  wire soc_bus_pkg::wr_req_t m_wr_req,
  output soc_bus_pkg::rd_rsp_t      m_rd_rsp,
  output soc_bus_pkg::wr_rsp_t      m_wr_rsp,
  output logic                      diff_skip
);

  soc_bus_pkg::rd_req_t mem_rd_req;
  soc_bus_pkg::rd_req_t rtc_rd_req;
  soc_bus_pkg::wr_req_t mem_wr_req;
  soc_bus_pkg::wr_req_t rtc_wr_req;
  soc_bus_pkg::rd_rsp_t mem_rd_rsp;
  soc_bus_pkg::rd_rsp_t rtc_rd_rsp;
  soc_bus_pkg::wr_rsp_t mem_wr_rsp;
  soc_bus_pkg::wr_rsp_t rtc_wr_rsp;

  axi_xbar u_xbar (
    .m_rd_req   (m_rd_req),
    .m_wr_req   (m_wr_req),
    .mem_rd_rsp (mem_rd_rsp),
    .rtc_rd_rsp (rtc_rd_rsp),
    .mem_wr_rsp (mem_wr_rsp),
    .rtc_wr_rsp (rtc_wr_rsp),
    .m_rd_rsp   (m_rd_rsp),
    .m_wr_rsp   (m_wr_rsp),
    .mem_rd_req (mem_rd_req),
    .rtc_rd_req (rtc_rd_req),
    .mem_wr_req (mem_wr_req),
    .rtc_wr_req (rtc_wr_req),
    .diff_skip  (diff_skip)
  );

  // also answers every address that is not the timer.
  sram_slave u_sram (
    .clock  (clock),
    .reset  (reset),
    .rd_req (mem_rd_req),
    .wr_req (mem_wr_req),
    .rd_rsp (mem_rd_rsp),
    .wr_rsp (mem_wr_rsp)
  );

  clint_timer u_clint (
    .clock  (clock),
    .reset  (reset),
    .rd_req (rtc_rd_req),
    .wr_req (rtc_wr_req),
    .rd_rsp (rtc_rd_rsp),
    .wr_rsp (rtc_wr_rsp)
  );

endmodule

`default_nettype wire

/* testbench/soc_bus_tb.sv */
`default_nettype none

module soc_bus_tb;

  localparam int NUM_TXN    = 300;
  localparam int MAX_CYCLES = NUM_TXN * 12;

  logic                 clock;
  logic                 reset;
  soc_bus_pkg::rd_req_t m_rd_req;
  soc_bus_pkg::wr_req_t m_wr_req;
  soc_bus_pkg::rd_rsp_t m_rd_rsp;
  soc_bus_pkg::wr_rsp_t m_wr_rsp;
  logic                 diff_skip;

  logic [31:0] lcg_state = 32'd71195;
  logic [63:0] shadow [soc_bus_pkg::SRAM_WORDS];
  // last value written to each mtime half, and the cycle it landed in.
  logic [31:0] rtc_value [2];
  int          rtc_cycle [2];
  int          cycle_count = 0;
  int          errors = 0;

  soc_bus_top DUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("error: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // later tests win, so they run in reverse decode priority.
  function automatic soc_bus_pkg::zone_e zone_of(input logic [31:0] addr);
    soc_bus_pkg::zone_e zone;
    zone = soc_bus_pkg::ZONE_OTHER;
    if (addr - soc_bus_pkg::GPIO_BASE < soc_bus_pkg::GPIO_SIZE) zone = soc_bus_pkg::ZONE_DEVICE;
    if (addr - soc_bus_pkg::SRAM_BASE < soc_bus_pkg::SRAM_SIZE) zone = soc_bus_pkg::ZONE_MEM;
    if (addr == soc_bus_pkg::RTC_ADDR || addr == soc_bus_pkg::RTC_ADDR_HIGH)
      zone = soc_bus_pkg::ZONE_RTC;
    if (addr - soc_bus_pkg::UART_BASE < soc_bus_pkg::UART_SIZE) zone = soc_bus_pkg::ZONE_DEVICE;
    return zone;
  endfunction

  function automatic logic is_skip(input logic [31:0] addr);
    return zone_of(addr) inside {soc_bus_pkg::ZONE_RTC, soc_bus_pkg::ZONE_DEVICE};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic read_txn(input logic [31:0] addr);
    soc_bus_pkg::zone_e zone;
    logic [63:0]        data;
    logic [1:0]         resp;
    logic [63:0]        high;
    int                 delay;
    int                 latency;
    int                 done;
    zone  = zone_of(addr);
    delay = int'(next_rand() >> 30);
    @(negedge clock);
    check_value("arready", 64'd1, 64'(m_rd_rsp.arready));
    m_rd_req = '{arvalid: 1'b1, araddr: addr, rready: 1'b0};
    latency = 0;
    do begin
      @(negedge clock);
      latency++;
    end while (!m_rd_rsp.rvalid);
    done = cycle_count;
    data = m_rd_rsp.rdata;
    resp = m_rd_rsp.rresp;
    check_value("rvalid latency", 64'd1, 64'(latency));
    check_value("diff_skip", 64'(is_skip(addr) || is_skip(m_wr_req.awaddr)), 64'(diff_skip));
    // arvalid stays high under back-pressure, so a second accept would show.
    repeat (delay) begin
      @(negedge clock);
      check_value("rvalid", 64'd1, 64'(m_rd_rsp.rvalid));
      check_value("arready", 64'd0, 64'(m_rd_rsp.arready));
      check_value("rdata", data, m_rd_rsp.rdata);
      check_value("rresp", 64'(resp), 64'(m_rd_rsp.rresp));
    end
    m_rd_req.arvalid = 1'b0;
    m_rd_req.rready  = 1'b1;
    @(negedge clock);
    check_value("rvalid", 64'd0, 64'(m_rd_rsp.rvalid));
    m_rd_req.rready = 1'b0;
    if (zone == soc_bus_pkg::ZONE_MEM) begin
      check_value("rresp", 64'(soc_bus_pkg::RESP_OKAY), 64'(resp));
      check_value("rdata", shadow[addr[9:3]], data);
    end else if (zone == soc_bus_pkg::ZONE_RTC) begin
      check_value("rresp", 64'(soc_bus_pkg::RESP_OKAY), 64'(resp));
      high = 64'(rtc_value[addr[2]]) + 64'(done - rtc_cycle[addr[2]]);
      assert (data >= 64'(rtc_value[addr[2]]) && data <= high) else begin
        errors++;
        $display("CHECK FAILED at %0t: rdata expected %0d to %0d, got %0d",
                 $time, rtc_value[addr[2]], high, data);
      end
    end else begin
      check_value("rresp", 64'(soc_bus_pkg::RESP_SLVERR), 64'(resp));
      check_value("rdata", 64'd0, data);
    end
  endtask

  task automatic write_txn(input logic [31:0] addr, input logic [63:0] wdata,
                           input logic [7:0] wstrb);
    soc_bus_pkg::zone_e zone;
    logic [63:0]        mask;
    logic [1:0]         resp;
    int                 delay;
    int                 latency;
    int                 done;
    zone  = zone_of(addr);
    delay = int'(next_rand() >> 30);
    @(negedge clock);
    check_value("bvalid", 64'd0, 64'(m_wr_rsp.bvalid));
    m_wr_req = '{awvalid: 1'b1, awaddr: addr, wvalid: 1'b1, wdata: wdata,
                 wstrb: wstrb, bready: 1'b0};
    latency = 0;
    do begin
      @(negedge clock);
      latency++;
    end while (!m_wr_rsp.bvalid);
    done = cycle_count;
    resp = m_wr_rsp.bresp;
    check_value("bvalid latency", 64'd1, 64'(latency));
    check_value("diff_skip", 64'(is_skip(m_rd_req.araddr) || is_skip(addr)), 64'(diff_skip));
    repeat (delay) begin
      @(negedge clock);
      check_value("bvalid", 64'd1, 64'(m_wr_rsp.bvalid));
      check_value("awready", 64'd0, 64'(m_wr_rsp.awready));
      check_value("wready", 64'd0, 64'(m_wr_rsp.wready));
      check_value("bresp", 64'(resp), 64'(m_wr_rsp.bresp));
    end
    m_wr_req.awvalid = 1'b0;
    m_wr_req.wvalid  = 1'b0;
    m_wr_req.bready  = 1'b1;
    @(negedge clock);
    check_value("bvalid", 64'd0, 64'(m_wr_rsp.bvalid));
    m_wr_req.bready = 1'b0;
    if (zone == soc_bus_pkg::ZONE_MEM) begin
      check_value("bresp", 64'(soc_bus_pkg::RESP_OKAY), 64'(resp));
      for (int i = 0; i < 8; i++) begin
        mask[8*i +: 8] = {8{wstrb[i]}};
      end
      shadow[addr[9:3]] = (shadow[addr[9:3]] & ~mask) | (wdata & mask);
    end else if (zone == soc_bus_pkg::ZONE_RTC) begin
      check_value("bresp", 64'(soc_bus_pkg::RESP_OKAY), 64'(resp));
      if (|wstrb[3:0]) begin
        rtc_value[addr[2]] = wdata[31:0];
        rtc_cycle[addr[2]] = done;
      end
    end else begin
      check_value("bresp", 64'(soc_bus_pkg::RESP_SLVERR), 64'(resp));
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [63:0] data;
    m_rd_req = '0;
    m_wr_req = '0;
    reset    = 1'b1;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset        = 1'b0;
    rtc_value[0] = '0;
    rtc_value[1] = '0;
    rtc_cycle[0] = cycle_count;
    rtc_cycle[1] = cycle_count;
    check_value("rvalid", 64'd0, 64'(m_rd_rsp.rvalid));
    check_value("bvalid", 64'd0, 64'(m_wr_rsp.bvalid));
    // mtime counts up from zero after reset.
    read_txn(soc_bus_pkg::RTC_ADDR);
    for (int i = 0; i < soc_bus_pkg::SRAM_WORDS; i++) begin
      addr = soc_bus_pkg::SRAM_BASE + 32'(i * 8);
      write_txn(addr, {addr ^ 32'h5a5a_5a5a, ~addr}, 8'hff);
    end
    for (int i = soc_bus_pkg::SRAM_WORDS + 1; i < NUM_TXN; i++) begin
      r = next_rand();
      case (r[31:29])
        3'd0, 3'd1, 3'd2: addr = soc_bus_pkg::SRAM_BASE + {22'd0, r[26:20], 3'd0};
        3'd3: addr = r[27] ? soc_bus_pkg::RTC_ADDR_HIGH : soc_bus_pkg::RTC_ADDR;
        3'd4: addr = soc_bus_pkg::UART_BASE + {20'd0, r[27:19], 3'd0};
        3'd5: addr = soc_bus_pkg::GPIO_BASE + {28'd0, r[27], 3'd0};
        default: addr = next_rand();
      endcase
      data = {next_rand(), next_rand()};
      // timer values stay clear of a 32-bit wrap.
      if (zone_of(addr) == soc_bus_pkg::ZONE_RTC) data[31] = 1'b0;
      if (r[28]) begin
        write_txn(addr, data, 8'(next_rand() >> 24));
      end else begin
        read_txn(addr);
      end
    end
    $display("summary: %0d errors in %0d transactions", errors, NUM_TXN);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/soc_bus_pkg.sv
logic/axi_xbar.sv
logic/sram_slave.sv
logic/clint_timer.sv
logic/soc_bus_top.sv
testbench/soc_bus_tb.sv

/* run.sh */
#!/bin/sh
# build and run the bus fabric testbench, then scan the log.
verilator --binary --timing --assert -f project.f --top-module soc_bus_tb -o soc_bus_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/soc_bus_sim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } \
  || echo "simulation passed"
